/* project.f */
+incdir+design
design/dot2_pkg.sv
design/fp_product_lane.sv
design/fp_sum_stage.sv
design/dot2_apb_ctrl.sv
design/dot2_top.sv
tb/dot2_asserts.sv
tb/dot2_tb.sv

/* tb/dot2_tb.sv */
`timescale 1ns/1ps
`include "dot2_params.svh"

module dot2_tb import dot2_pkg::*; ();

	// About 200 transfers in all, 400 ns allowed for each
	localparam int TRANSFER_BUDGET = 260;
	localparam int WATCHDOG_NS = TRANSFER_BUDGET * 400 + 8 * 40 + 2000;

	logic iCLK;
	logic reset_key;
	apb_addr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic pready;
	logic pslverr;
	logic last_err;
	logic [31:0] rng_state;

	dot2_top dot2_top_inst (
		.iCLK(iCLK), .reset_key(reset_key),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	// 40 ns clock
	initial begin
		iCLK = 1'b0;
		forever #20 iCLK = ~iCLK;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

	// Bound checker failures end the run
	initial begin
		wait (dot2_top_inst.asserts_inst.fail_count != 0);
		$display("A bound assertion failed at %0t ns", $time);
		$display("Test failed");
		$fatal(1, "assertion failure");
	end

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, actual, expected);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// ==================================================
	// APB driver, setup then access then idle
	// ==================================================
	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		@(posedge iCLK);
		paddr <= addr;
		pwdata <= data;
		pwrite <= 1'b1;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge iCLK);
		penable <= 1'b1;
		// Mid access cycle, outputs settled
		@(negedge iCLK);
		last_err = pslverr;
		check(pready, 1'b1, "pready in write access cycle");
		@(posedge iCLK);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
		@(posedge iCLK);
		paddr <= addr;
		pwrite <= 1'b0;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge iCLK);
		penable <= 1'b1;
		@(negedge iCLK);
		data = prdata;
		last_err = pslverr;
		check(pready, 1'b1, "pready in read access cycle");
		@(posedge iCLK);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// ==================================================
	// Reference model and stimulus helpers
	// ==================================================
	function automatic logic [31:0] expected_dot(input int a, input int b, input int c,
		input int d);
		int s;
		s = a * b + c * d;
		// Clip symmetric at the integer limit
		if (s > `INT_MAX) begin
			s = `INT_MAX;
		end else if (s < -`INT_MAX) begin
			s = -`INT_MAX;
		end
		return 32'(s);
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_operand(output int value);
		rng_state = xorshift32(rng_state);
		// Spread over -127..127
		value = int'(rng_state % 32'd255) - 127;
	endtask

	task automatic wait_done();
		apb_data_t status;
		status = '0;
		// Watchdog bounds this poll
		while (!status[1]) begin
			apb_read(`REG_STATUS, status);
		end
	endtask

	task automatic run_dot(input int a, input int b, input int c, input int d);
		apb_write(`REG_AB, {16'(b), 16'(a)});
		apb_write(`REG_CD, {16'(d), 16'(c)});
		apb_write(`REG_CTRL, 32'd1);
		wait_done();
	endtask

	task automatic check_dot(input int a, input int b, input int c, input int d,
		input string what);
		apb_data_t data;
		run_dot(a, b, c, d);
		apb_read(`REG_RESULT_INT, data);
		check(data, expected_dot(a, b, c, d), what);
	endtask

	// ==================================================
	// Directed tests
	// ==================================================
	task automatic test_reset_values();
		apb_data_t data;
		apb_read(`REG_STATUS, data);
		check(data, 32'd0, "status after reset");
		apb_read(`REG_RESULT_INT, data);
		check(data, 32'd0, "integer result after reset");
		apb_read(`REG_RESULT_FP, data);
		check(data, 32'd0, "float result after reset");
	endtask

	task automatic test_unit_and_zero();
		apb_data_t data;
		run_dot(1, 1, 0, 0);
		apb_read(`REG_RESULT_INT, data);
		check(data, 32'd1, "1*1 + 0*0 integer");
		apb_read(`REG_RESULT_FP, data);
		// 1.0 is the bare bias in the exponent field
		check(data, 32'(`FP_EXP_BIAS) << `FP_FRAC_WIDTH, "1*1 + 0*0 float");
		run_dot(0, 0, 0, 0);
		apb_read(`REG_RESULT_INT, data);
		check(data, 32'd0, "all zero integer");
		apb_read(`REG_RESULT_FP, data);
		check(data, 32'd0, "all zero float");
	endtask

	task automatic test_random();
		int a;
		int b;
		int c;
		int d;
		for (int i = 0; i < 20; i++) begin
			next_operand(a);
			next_operand(b);
			next_operand(c);
			next_operand(d);
			check_dot(a, b, c, d, $sformatf("random set %0d", i));
		end
	endtask

	task automatic test_saturation();
		check_dot(300, 300, 0, 0, "positive clip");
		check_dot(300, -300, 0, 0, "negative clip");
	endtask

	task automatic test_busy_ignored();
		apb_data_t data;
		apb_write(`REG_AB, {16'(6), 16'(5)});
		apb_write(`REG_CD, {16'(2), 16'(-7)});
		apb_write(`REG_CTRL, 32'd1);
		// Lands on the last busy edge
		apb_write(`REG_AB, {16'(100), 16'(100)});
		wait_done();
		apb_read(`REG_RESULT_INT, data);
		check(data, expected_dot(5, 6, -7, 2), "result with operand write while busy");
		apb_read(`REG_AB, data);
		check(data, {16'(6), 16'(5)}, "operands kept while busy");
		apb_write(`REG_CTRL, 32'd1);
		apb_write(`REG_CTRL, 32'd1);
		apb_read(`REG_STATUS, data);
		check(data, 32'd2, "second start while busy ignored");
		apb_read(`REG_RESULT_INT, data);
		check(data, expected_dot(5, 6, -7, 2), "result after ignored start");
	endtask

	task automatic test_unmapped();
		apb_data_t data;
		apb_write(`REG_AB, {16'(-1234), 16'(567)});
		check(last_err, 1'b0, "pslverr on mapped write");
		apb_write(`REG_CD, {16'(32767), 16'(-32768)});
		// Unmapped accesses must leave the operands alone
		apb_write(8'h18, 32'hdead_beef);
		check(last_err, 1'b1, "pslverr on unmapped write");
		apb_read(8'h18, data);
		check(last_err, 1'b1, "pslverr on unmapped read");
		check(data, 32'd0, "unmapped read data");
		apb_read(`REG_AB, data);
		check(data, {16'(-1234), 16'(567)}, "AB readback");
		apb_read(`REG_CD, data);
		check(data, {16'(32767), 16'(-32768)}, "CD readback");
	endtask

	initial begin
		reset_key = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		last_err = 1'b0;
		rng_state = 32'h86f6_b38d;
		repeat (8) @(posedge iCLK);
		reset_key <= 1'b0;
		test_reset_values();
		test_unit_and_zero();
		test_random();
		test_saturation();
		test_busy_ignored();
		test_unmapped();
		// Assertion results of the last edge land first
		@(negedge iCLK);
		$display("Test passed");
		$finish;
	end

endmodule

/* tb/dot2_asserts.sv */
`timescale 1ns/1ps
`include "dot2_params.svh"

module dot2_asserts import dot2_pkg::*; (
	input logic      iCLK,
	input logic      reset_key,
	input apb_addr_t paddr,
	input logic      psel,
	input logic      penable,
	input logic      pwrite,
	input apb_data_t pwdata,
	input logic      pslverr,
	input logic      busy,
	input logic      done
);

	logic start_seen;
	// Failed assertions so far
	int fail_count = 0;

	// Access cycle of a CTRL write with bit 0 set, controller idle
	assign start_seen = psel && penable && pwrite && (paddr == `REG_CTRL) && pwdata[0] && !busy;

	// ==================================================
	// APB and status checks
	// ==================================================
	slverr_in_access: assert property (@(posedge iCLK) disable iff (reset_key)
		pslverr |-> (psel && penable))
		else begin
			$error("pslverr high outside an access cycle");
			fail_count = fail_count + 1;
		end

	busy_done_exclusive: assert property (@(posedge iCLK) disable iff (reset_key)
		!(busy && done))
		else begin
			$error("busy and done high together");
			fail_count = fail_count + 1;
		end

	// Done lands on the third edge after the start edge
	done_latency: assert property (@(posedge iCLK) disable iff (reset_key)
		start_seen |=> (!done)[*`DOT2_LATENCY] ##1 done)
		else begin
			$error("done did not rise at the expected latency");
			fail_count = fail_count + 1;
		end

	status_after_reset: assert property (@(posedge iCLK)
		reset_key |=> (!busy && !done))
		else begin
			$error("busy or done set after reset");
			fail_count = fail_count + 1;
		end

endmodule

// Attached to every dot2_top
bind dot2_top dot2_asserts asserts_inst (
	.iCLK(iCLK), .reset_key(reset_key),
	.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
	.pwdata(pwdata), .pslverr(pslverr),
	.busy(ctrl_inst.busy), .done(ctrl_inst.done)
);

/* design/dot2_top.sv */
`timescale 1ns/1ps

module dot2_top import dot2_pkg::*; (
	input  logic      iCLK,
	input  logic      reset_key,
	input  apb_addr_t paddr,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	output logic      pready,
	output logic      pslverr
);

	int_word_t op_a;
	int_word_t op_b;
	int_word_t op_c;
	int_word_t op_d;
	fp_word_t prod_ab;
	fp_word_t prod_cd;
	fp_word_t sum;
	int_word_t sum_int;

	// Register block and sequencing
	dot2_apb_ctrl ctrl_inst (
		.iCLK(iCLK), .reset_key(reset_key),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.op_a(op_a), .op_b(op_b), .op_c(op_c), .op_d(op_d),
		.sum(sum), .sum_int(sum_int)
	);

	// Lanes run side by side
	fp_product_lane lane_ab (.iCLK(iCLK), .a(op_a), .b(op_b), .product(prod_ab));
	fp_product_lane lane_cd (.iCLK(iCLK), .a(op_c), .b(op_d), .product(prod_cd));

	// a*b + c*d, two stages
	fp_sum_stage sum_inst (
		.iCLK(iCLK), .lhs(prod_ab), .rhs(prod_cd),
		.sum(sum), .sum_int(sum_int)
	);

endmodule

/* design/dot2_apb_ctrl.sv */
`timescale 1ns/1ps
`include "dot2_params.svh"

module dot2_apb_ctrl import dot2_pkg::*; (
	input  logic      iCLK,
	input  logic      reset_key,
	// APB slave
	input  apb_addr_t paddr,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	output logic      pready,
	output logic      pslverr,
	// Operands to the lanes
	output int_word_t op_a,
	output int_word_t op_b,
	output int_word_t op_c,
	output int_word_t op_d,
	// Summing stage results
	input  fp_word_t  sum,
	input  int_word_t sum_int
);

	ctrl_state_t state;
	logic [1:0] cycle_cnt;
	logic busy;
	logic done;
	logic access;
	logic wr_en;
	logic rd_en;
	logic addr_hit;
	logic start;
	fp_word_t result_fp;
	int_word_t result_int;

	// ==================================================
	// APB decode
	// ==================================================
	// Access phase only, no wait states
	assign access = psel & penable;
	assign wr_en = access & pwrite;
	assign rd_en = access & ~pwrite;
	assign pready = 1'b1;

	always_comb begin
		case (paddr)
			`REG_AB, `REG_CD, `REG_CTRL, `REG_STATUS,
			`REG_RESULT_INT, `REG_RESULT_FP: addr_hit = 1'b1;
			default: addr_hit = 1'b0;
		endcase
	end

	// Error on an unmapped offset
	assign pslverr = access & ~addr_hit;

	assign busy = (state == CTRL_BUSY);
	// Start only counts while idle
	assign start = wr_en && (paddr == `REG_CTRL) && pwdata[0] && !busy;

	// Operands frozen for the whole computation
	always_ff @(posedge iCLK) begin
		if (reset_key) begin
			op_a <= '0;
			op_b <= '0;
			op_c <= '0;
			op_d <= '0;
		end else if (wr_en && !busy) begin
			if (paddr == `REG_AB) begin
				op_a <= pwdata[15:0];
				op_b <= pwdata[31:16];
			end
			if (paddr == `REG_CD) begin
				op_c <= pwdata[15:0];
				op_d <= pwdata[31:16];
			end
		end
	end

	// ==================================================
	// Start, countdown, capture
	// ==================================================
	always_ff @(posedge iCLK) begin
		if (reset_key) begin
			state <= CTRL_IDLE;
			cycle_cnt <= '0;
			done <= 1'b0;
			result_fp <= '0;
			result_int <= '0;
		end else begin
			case (state)
				CTRL_IDLE: begin
					if (start) begin
						state <= CTRL_BUSY;
						cycle_cnt <= 2'(`DOT2_LATENCY - 1);
						done <= 1'b0;
					end
				end
				CTRL_BUSY: begin
					// Last busy edge latches the launched item
					if (cycle_cnt == 0) begin
						state <= CTRL_IDLE;
						done <= 1'b1;
						result_fp <= sum;
						result_int <= sum_int;
					end else begin
						cycle_cnt <= cycle_cnt - 2'd1;
					end
				end
				default: state <= CTRL_IDLE;
			endcase
		end
	end

	// ==================================================
	// Read mux
	// ==================================================
	always_comb begin
		prdata = '0;
		if (rd_en) begin
			case (paddr)
				`REG_AB: prdata = {op_b, op_a};
				`REG_CD: prdata = {op_d, op_c};
				`REG_STATUS: prdata = {30'b0, done, busy};
				// Sign extended to the bus
				`REG_RESULT_INT: prdata = {{16{result_int[15]}}, result_int};
				`REG_RESULT_FP: prdata = {{(`APB_DATA_WIDTH-`FP_WIDTH){1'b0}}, result_fp};
				default: prdata = '0;
			endcase
		end
	end

endmodule

/* design/fp_sum_stage.sv */
`timescale 1ns/1ps
`include "dot2_params.svh"

module fp_sum_stage import dot2_pkg::*; (
	input  logic      iCLK,
	input  fp_word_t  lhs,
	input  fp_word_t  rhs,
	output fp_word_t  sum,
	output int_word_t sum_int
);

	fp_exp_t lhs_exp;
	fp_exp_t rhs_exp;
	fp_frac_t lhs_man;
	fp_frac_t rhs_man;
	fp_exp_t diff_lhs;
	fp_exp_t diff_rhs;
	fp_exp_t larger_exp;
	logic lhs_larger;
	logic [2*`FP_FRAC_WIDTH:0] lhs_aligned;
	logic [2*`FP_FRAC_WIDTH:0] rhs_aligned;
	logic [2*`FP_FRAC_WIDTH:0] pre_sum;

	// ==================================================
	// Stage 1, align and add
	// ==================================================
	assign lhs_exp = lhs[`FP_WIDTH-2:`FP_FRAC_WIDTH];
	assign rhs_exp = rhs[`FP_WIDTH-2:`FP_FRAC_WIDTH];
	assign lhs_man = {1'b1, lhs[`FP_FRAC_WIDTH-1:1]};
	assign rhs_man = {1'b1, rhs[`FP_FRAC_WIDTH-1:1]};
	assign diff_lhs = rhs_exp - lhs_exp;
	assign diff_rhs = lhs_exp - rhs_exp;
	assign larger_exp = (rhs_exp > lhs_exp) ? rhs_exp : lhs_exp;
	// Magnitude order, fraction breaks an exponent tie
	assign lhs_larger = (lhs_exp > rhs_exp) || (lhs_exp == rhs_exp && lhs_man > rhs_man);

	// Smaller operand shifts right, gone entirely past 35
	assign lhs_aligned = lhs_larger ? {1'b0, lhs_man, {`FP_FRAC_WIDTH{1'b0}}} :
		(diff_lhs > 8'd35) ? '0 : ({1'b0, lhs_man, {`FP_FRAC_WIDTH{1'b0}}} >> diff_lhs);
	assign rhs_aligned = !lhs_larger ? {1'b0, rhs_man, {`FP_FRAC_WIDTH{1'b0}}} :
		(diff_rhs > 8'd35) ? '0 : ({1'b0, rhs_man, {`FP_FRAC_WIDTH{1'b0}}} >> diff_rhs);

	// Unlike signs subtract the smaller magnitude
	assign pre_sum = (lhs[`FP_WIDTH-1] ^ rhs[`FP_WIDTH-1]) ?
		(lhs_larger ? lhs_aligned - rhs_aligned : rhs_aligned - lhs_aligned) :
		lhs_aligned + rhs_aligned;

	logic [2*`FP_FRAC_WIDTH:0] s1_pre_sum;
	fp_exp_t s1_larger_exp;
	logic s1_lhs_zero;
	logic s1_rhs_zero;
	fp_word_t s1_lhs;
	fp_word_t s1_rhs;
	logic s1_sign;

	always_ff @(posedge iCLK) begin
		s1_pre_sum <= pre_sum;
		s1_larger_exp <= larger_exp;
		s1_lhs_zero <= (lhs_exp == 0);
		s1_rhs_zero <= (rhs_exp == 0);
		s1_lhs <= lhs;
		s1_rhs <= rhs;
		// Result takes the sign of the larger magnitude
		s1_sign <= lhs_larger ? lhs[`FP_WIDTH-1] : rhs[`FP_WIDTH-1];
	end

	// ==================================================
	// Stage 2, normalise and register
	// ==================================================
	fp_exp_t shft;
	logic [3*`FP_FRAC_WIDTH-1:0] frac_shift;
	fp_exp_t sum_exp;
	logic underflow;

	// Leading one, 37 means nothing is left
	always_comb begin
		shft = fp_exp_t'(2 * `FP_FRAC_WIDTH + 1);
		for (int i = 0; i <= 2 * `FP_FRAC_WIDTH; i++) begin
			if (s1_pre_sum[i]) begin
				shft = fp_exp_t'(2 * `FP_FRAC_WIDTH - i);
			end
		end
	end

	// Extra place drops the hidden one
	assign frac_shift = {s1_pre_sum, {(`FP_FRAC_WIDTH-1){1'b0}}} << (shft + 1);
	assign sum_exp = s1_larger_exp - shft + 8'd1;
	// Cancelled to zero or exponent below 1
	assign underflow = (s1_pre_sum == 0) || (s1_larger_exp < shft);

	always_ff @(posedge iCLK) begin
		if (s1_lhs_zero && s1_rhs_zero) begin
			sum <= '0;
		end else if (s1_lhs_zero) begin
			sum <= s1_rhs;
		end else if (s1_rhs_zero) begin
			sum <= s1_lhs;
		end else if (underflow) begin
			sum <= '0;
		end else begin
			sum <= {s1_sign, sum_exp, frac_shift[3*`FP_FRAC_WIDTH-1 -: `FP_FRAC_WIDTH]};
		end
	end

	// ==================================================
	// Float to integer, clipped
	// ==================================================
	fp_exp_t sum_e;
	logic [`INT_WIDTH+`FP_FRAC_WIDTH-1:0] int_shift;
	int_word_t int_mag;

	assign sum_e = sum[`FP_WIDTH-2:`FP_FRAC_WIDTH];
	// 1.frac moved up by the unbiased exponent
	assign int_shift = {{(`INT_WIDTH-1){1'b0}}, 1'b1, sum[`FP_FRAC_WIDTH-1:0]}
		<< fp_exp_t'(sum_e - `FP_EXP_BIAS);
	assign int_mag = int_shift[`INT_WIDTH+`FP_FRAC_WIDTH-1:`FP_FRAC_WIDTH];

	always_comb begin
		if (sum_e < `FP_EXP_BIAS) begin
			sum_int = '0;
		end else if (sum_e > `FP_EXP_BIAS + `INT_WIDTH - 2) begin
			sum_int = sum[`FP_WIDTH-1] ? int_word_t'(-`INT_MAX) : int_word_t'(`INT_MAX);
		end else begin
			sum_int = sum[`FP_WIDTH-1] ? -int_mag : int_mag;
		end
	end

endmodule

/* design/fp_product_lane.sv */
`timescale 1ns/1ps
`include "dot2_params.svh"

module fp_product_lane import dot2_pkg::*; (
	input  logic      iCLK,
	input  int_word_t a,
	input  int_word_t b,
	output fp_word_t  product
);

	// ==================================================
	// Integer to float
	// ==================================================
	function automatic fp_word_t int_to_fp(input int_word_t value);
		logic [`INT_WIDTH-1:0] mag;
		fp_exp_t shft;
		fp_exp_t exp;
		logic [`INT_WIDTH+`FP_FRAC_WIDTH-1:0] shift_buf;
		// Magnitude, 16'h8000 is still right read as unsigned
		mag = value[`INT_WIDTH-1] ? -value : value;
		// Leading one search, highest set bit wins
		shft = fp_exp_t'(`FP_FRAC_WIDTH + 1);
		for (int i = 0; i < `INT_WIDTH; i++) begin
			if (mag[i]) begin
				shft = fp_exp_t'(`FP_FRAC_WIDTH - i);
			end
		end
		// Bias + 18 - shift
		exp = fp_exp_t'(`FP_EXP_BIAS + `FP_FRAC_WIDTH) - shft;
		// Hidden one ends up on bit 18 and drops off
		shift_buf = {{`FP_FRAC_WIDTH{1'b0}}, mag} << shft;
		if (value == 0) begin
			return '0;
		end
		return {value[`INT_WIDTH-1], exp, shift_buf[`FP_FRAC_WIDTH-1:0]};
	endfunction

	fp_word_t fa;
	fp_word_t fb;
	fp_exp_t a_exp;
	fp_exp_t b_exp;
	fp_frac_t a_man;
	fp_frac_t b_man;
	logic [2*`FP_FRAC_WIDTH-1:0] man_prod;
	logic [`FP_EXP_WIDTH:0] exp_sum;
	fp_exp_t prod_exp;
	fp_frac_t prod_frac;
	logic underflow;

	assign fa = int_to_fp(a);
	assign fb = int_to_fp(b);
	assign a_exp = fa[`FP_WIDTH-2:`FP_FRAC_WIDTH];
	assign b_exp = fb[`FP_WIDTH-2:`FP_FRAC_WIDTH];

	// ==================================================
	// Float multiply
	// ==================================================
	// Hidden one restored, fraction LSB dropped
	assign a_man = {1'b1, fa[`FP_FRAC_WIDTH-1:1]};
	assign b_man = {1'b1, fb[`FP_FRAC_WIDTH-1:1]};
	assign man_prod = a_man * b_man;
	// Nine bits so the carry survives
	assign exp_sum = a_exp + b_exp;

	// Renormalise on a carry into the top bit
	assign prod_exp = man_prod[2*`FP_FRAC_WIDTH-1] ?
		fp_exp_t'(exp_sum - (`FP_EXP_BIAS - 1)) : fp_exp_t'(exp_sum - `FP_EXP_BIAS);
	assign prod_frac = man_prod[2*`FP_FRAC_WIDTH-1] ?
		man_prod[2*`FP_FRAC_WIDTH-2 -: `FP_FRAC_WIDTH] :
		man_prod[2*`FP_FRAC_WIDTH-3 -: `FP_FRAC_WIDTH];
	assign underflow = exp_sum < (`FP_EXP_BIAS + 1);

	// One cycle from operands to product
	always_ff @(posedge iCLK) begin
		if (underflow || a_exp == 0 || b_exp == 0) begin
			product <= '0;
		end else begin
			product <= {fa[`FP_WIDTH-1] ^ fb[`FP_WIDTH-1], prod_exp, prod_frac};
		end
	end

endmodule

/* design/dot2_pkg.sv */
`include "dot2_params.svh"

package dot2_pkg;

	// ==================================================
	// Datapath words
	// ==================================================
	// Packed float {sign, exponent, fraction}
	typedef logic [`FP_WIDTH-1:0] fp_word_t;
	typedef logic [`FP_EXP_WIDTH-1:0] fp_exp_t;
	// Fraction without the hidden one
	typedef logic [`FP_FRAC_WIDTH-1:0] fp_frac_t;
	// Two's complement operand or result
	typedef logic signed [`INT_WIDTH-1:0] int_word_t;

	// Bus words
	typedef logic [`APB_ADDR_WIDTH-1:0] apb_addr_t;
	typedef logic [`APB_DATA_WIDTH-1:0] apb_data_t;

	// Controller sequence
	typedef enum logic {
		CTRL_IDLE,
		CTRL_BUSY
	} ctrl_state_t;

endpackage

/* design/dot2_params.svh */
`ifndef DOT2_PARAMS_SVH
`define DOT2_PARAMS_SVH

// Float format, 1 sign, 8 exponent, 18 fraction
`define FP_WIDTH        27
`define FP_EXP_WIDTH    8
`define FP_FRAC_WIDTH   18
`define FP_EXP_BIAS     127

// Integer operands and clip level
`define INT_WIDTH       16
`define INT_MAX         32767

// Edges from accepted start to result capture
`define DOT2_LATENCY    3

// APB bus widths and register map
`define APB_ADDR_WIDTH  8
`define APB_DATA_WIDTH  32
`define REG_AB          8'h00
`define REG_CD          8'h04
`define REG_CTRL        8'h08
`define REG_STATUS      8'h0C
`define REG_RESULT_INT  8'h10
`define REG_RESULT_FP   8'h14

`endif
